// ==== logic/lookup_cfg.svh ====
// Widths, depths and ids of the match-action lookup stage.
// Included by both packages and by every RTL module that needs a size or id.
`ifndef LOOKUP_CFG_SVH
`define LOOKUP_CFG_SVH

// datapath widths
`define KEY_W           24
`define ACT_W           48
`define PHV_W           64
`define CTRL_W          64

// table size, 16 entries share one index
`define CAM_DEPTH       16
`define IDX_W           4

// who this stage is on the control ring
`define STAGE_ID        5'd1
`define LOOKUP_ID       3'd2
`define RESV_CAM        4'd0
`define RESV_ACT        4'd2

// header field widths, from the msb of a beat down
`define HDR_STAGE_W     5
`define HDR_LOOKUP_W    3
`define HDR_RESV_W      4
`define HDR_INDEX_W     8
`define HDR_PAD_W       (`CTRL_W - 20)

// miss result
`define DEFAULT_ACTION  (`ACT_W'('h3f))

`endif

// ==== logic/ctrl_pkg.sv ====
// Types of the control stream. One beat is decoded as a header when it
// opens a packet, and as a payload for every beat after that.
`include "lookup_cfg.svh"

package ctrl_pkg;

    // first beat of a packet, stage and lookup pick the target table
    typedef struct packed {
        logic [`HDR_STAGE_W-1:0]  stage;
        logic [`HDR_LOOKUP_W-1:0] lookup;
        logic [`HDR_RESV_W-1:0]   resv;
        logic [`HDR_INDEX_W-1:0]  index;
        logic [`HDR_PAD_W-1:0]    unused;
    } ctrl_hdr_t;

    // later beats, key or mask in the low KEY_W bits, action in the low ACT_W
    typedef struct packed {
        logic [`CTRL_W-`ACT_W-1:0] unused;
        logic [`ACT_W-1:0]         data;
    } ctrl_payload_t;

    typedef union packed {
        ctrl_hdr_t     hdr;
        ctrl_payload_t payload;
    } ctrl_beat_u;

endpackage

// ==== logic/lookup_pkg.sv ====
// Types of the lookup datapath, shared by the CAM, action table and
// result stage.
`include "lookup_cfg.svh"

package lookup_pkg;

    // lookup key, also used for the ternary masks
    typedef logic [`KEY_W-1:0] key_t;

    typedef logic [`ACT_W-1:0] action_t;

    // packet header vector, carried alongside the lookup
    typedef logic [`PHV_W-1:0] phv_t;

    // address into both the CAM and the action table
    typedef logic [`IDX_W-1:0] tbl_idx_t;

endpackage

// ==== logic/ctrl_decoder.sv ====
// Control stream decoder. Packets aimed at this stage and lookup write CAM
// pairs or one action entry; all other packets are passed on one cycle later.
`include "lookup_cfg.svh"

module ctrl_decoder
    import ctrl_pkg::*;
    import lookup_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  ctrl_beat_u c_in_data,
    input  logic       c_in_valid,
    input  logic       c_in_last,

    output ctrl_beat_u c_out_data,
    output logic       c_out_valid,
    output logic       c_out_last,

    output logic       cam_wr_en,
    output tbl_idx_t   cam_wr_idx,
    output key_t       cam_wr_key,
    output key_t       cam_wr_mask,

    output logic       act_wr_en,
    output tbl_idx_t   act_wr_idx,
    output action_t    act_wr_data
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CAM_ENTRY,
        S_CAM_MASK,
        S_ACT,
        S_FWD
    } state_t;

    state_t   state;
    tbl_idx_t idx;
    key_t     entry_r;
    logic     hdr_ours;
    key_t     beat_key;

    assign hdr_ours = (c_in_data.hdr.stage == `STAGE_ID) &&
                      (c_in_data.hdr.lookup == `LOOKUP_ID);
    assign beat_key = c_in_data.payload.data[`KEY_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            idx         <= '0;
            cam_wr_en   <= 1'b0;
            act_wr_en   <= 1'b0;
            c_out_valid <= 1'b0;
            c_out_last  <= 1'b0;
        end else begin
            // strobes are single-cycle pulses
            cam_wr_en   <= 1'b0;
            act_wr_en   <= 1'b0;
            c_out_valid <= 1'b0;
            c_out_last  <= 1'b0;

            if (c_in_valid) begin
                case (state)
                    S_IDLE: begin
                        idx <= c_in_data.hdr.index[`IDX_W-1:0];
                        if (hdr_ours && c_in_data.hdr.resv == `RESV_CAM) begin
                            // a header with last carries no pairs
                            if (!c_in_last) begin
                                state <= S_CAM_ENTRY;
                            end
                        end else if (hdr_ours && c_in_data.hdr.resv == `RESV_ACT) begin
                            if (!c_in_last) begin
                                state <= S_ACT;
                            end
                        end else begin
                            c_out_valid <= 1'b1;
                            c_out_last  <= c_in_last;
                            if (!c_in_last) begin
                                state <= S_FWD;
                            end
                        end
                    end

                    S_CAM_ENTRY: begin
                        state <= c_in_last ? S_IDLE : S_CAM_MASK;
                    end

                    S_CAM_MASK: begin
                        cam_wr_en <= 1'b1;
                        idx       <= idx + 1'b1;
                        state     <= c_in_last ? S_IDLE : S_CAM_ENTRY;
                    end

                    // single action beat, expected to carry last
                    S_ACT: begin
                        act_wr_en <= 1'b1;
                        state     <= S_IDLE;
                    end

                    S_FWD: begin
                        c_out_valid <= 1'b1;
                        c_out_last  <= c_in_last;
                        if (c_in_last) begin
                            state <= S_IDLE;
                        end
                    end

                    default: begin
                        state <= S_IDLE;
                    end
                endcase
            end
        end
    end

    // data side, only looked at when the matching strobe is high
    always_ff @(posedge clk) begin
        c_out_data  <= c_in_data;
        cam_wr_idx  <= idx;
        cam_wr_key  <= entry_r;
        cam_wr_mask <= beat_key;
        act_wr_idx  <= idx;
        act_wr_data <= c_in_data.payload.data;
        // entry waits here for its mask beat
        if (c_in_valid && state == S_CAM_ENTRY) begin
            entry_r <= beat_key;
        end
    end

endmodule

// ==== logic/key_cam.sv ====
// 16-entry ternary CAM. Every entry is compared in parallel and the lowest
// matching index is registered one cycle after the key is sampled.
`include "lookup_cfg.svh"

module key_cam
    import lookup_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    input  logic     wr_en,
    input  tbl_idx_t wr_idx,
    input  key_t     wr_key,
    input  key_t     wr_mask,

    input  logic     key_valid,
    input  key_t     lookup_key,
    input  key_t     lookup_mask,

    output logic     hit_valid,
    output logic     hit,
    output tbl_idx_t hit_idx
);

    key_t                  ent_key  [`CAM_DEPTH];
    key_t                  ent_mask [`CAM_DEPTH];
    logic [`CAM_DEPTH-1:0] ent_valid;
    logic [`CAM_DEPTH-1:0] match_vec;
    tbl_idx_t              first_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ent_valid <= '0;
        end else if (wr_en) begin
            ent_valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            ent_key[wr_idx]  <= wr_key;
            ent_mask[wr_idx] <= wr_mask;
        end
    end

    // a 1 in either mask makes that bit don't care
    always_comb begin
        for (int i = 0; i < `CAM_DEPTH; i++) begin
            match_vec[i] = ent_valid[i] &&
                (((ent_key[i] ^ lookup_key) & ~(ent_mask[i] | lookup_mask)) == '0);
        end
    end

    // walk down so the lowest index is the one left standing
    always_comb begin
        first_idx = '0;
        for (int i = `CAM_DEPTH - 1; i >= 0; i--) begin
            if (match_vec[i]) begin
                first_idx = tbl_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_valid <= 1'b0;
            hit       <= 1'b0;
        end else begin
            hit_valid <= key_valid;
            hit       <= key_valid && (|match_vec);
        end
    end

    always_ff @(posedge clk) begin
        hit_idx <= first_idx;
    end

endmodule

// ==== logic/action_table.sv ====
// Action memory, one word per CAM entry. Written by the control decoder,
// read every cycle at the CAM's hit index with one cycle of latency.
`include "lookup_cfg.svh"

module action_table
    import lookup_pkg::*;
(
    input  logic     clk,

    input  logic     wr_en,
    input  tbl_idx_t wr_idx,
    input  action_t  wr_data,

    input  tbl_idx_t rd_idx,
    output action_t  rd_action
);

    action_t mem [`CAM_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // same-edge read and write returns the old word
    always_ff @(posedge clk) begin
        rd_action <= mem[rd_idx];
    end

endmodule

// ==== logic/lookup_result.sv ====
// Output stage of the lookup. Lines the phv and the CAM hit up with the
// table read, then registers the table action on a hit or the default on a miss.
`include "lookup_cfg.svh"

module lookup_result
    import lookup_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,

    input  logic    key_valid,
    input  phv_t    phv_in,

    input  logic    hit_valid,
    input  logic    hit,
    input  action_t rd_action,

    output action_t action,
    output logic    action_valid,
    output phv_t    phv_out
);

    phv_t phv_d1;
    phv_t phv_d2;
    logic hit_d;
    logic hit_valid_d;

    // phv trails the key by the same three edges as the action
    always_ff @(posedge clk) begin
        if (key_valid) begin
            phv_d1 <= phv_in;
        end
        phv_d2  <= phv_d1;
        phv_out <= phv_d2;
    end

    // hit needs one more stage to meet the registered table read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_d        <= 1'b0;
            hit_valid_d  <= 1'b0;
            action_valid <= 1'b0;
        end else begin
            hit_d        <= hit;
            hit_valid_d  <= hit_valid;
            action_valid <= hit_valid_d;
        end
    end

    always_ff @(posedge clk) begin
        action <= hit_d ? rd_action : `DEFAULT_ACTION;
    end

endmodule

// ==== logic/lookup_engine.sv ====
// Match-action lookup stage. A key goes through the ternary CAM and the
// action table and comes out with its phv three cycles later; the control
// stream writes both tables and passes other packets along.
`include "lookup_cfg.svh"

module lookup_engine
    import ctrl_pkg::*;
    import lookup_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // from the key extractor
    input  logic       key_valid,
    input  key_t       extract_key,
    input  key_t       extract_mask,
    input  phv_t       phv_in,

    // to the action engine
    output action_t    action,
    output logic       action_valid,
    output phv_t       phv_out,

    // control ring
    input  ctrl_beat_u c_in_data,
    input  logic       c_in_valid,
    input  logic       c_in_last,
    output ctrl_beat_u c_out_data,
    output logic       c_out_valid,
    output logic       c_out_last
);

    logic     cam_wr_en;
    tbl_idx_t cam_wr_idx;
    key_t     cam_wr_key;
    key_t     cam_wr_mask;

    logic     act_wr_en;
    tbl_idx_t act_wr_idx;
    action_t  act_wr_data;

    logic     hit_valid;
    logic     hit;
    tbl_idx_t hit_idx;
    action_t  rd_action;

    ctrl_decoder ctrl_decoder_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .c_in_data   (c_in_data),
        .c_in_valid  (c_in_valid),
        .c_in_last   (c_in_last),
        .c_out_data  (c_out_data),
        .c_out_valid (c_out_valid),
        .c_out_last  (c_out_last),
        .cam_wr_en   (cam_wr_en),
        .cam_wr_idx  (cam_wr_idx),
        .cam_wr_key  (cam_wr_key),
        .cam_wr_mask (cam_wr_mask),
        .act_wr_en   (act_wr_en),
        .act_wr_idx  (act_wr_idx),
        .act_wr_data (act_wr_data)
    );

    key_cam key_cam_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_en       (cam_wr_en),
        .wr_idx      (cam_wr_idx),
        .wr_key      (cam_wr_key),
        .wr_mask     (cam_wr_mask),
        .key_valid   (key_valid),
        .lookup_key  (extract_key),
        .lookup_mask (extract_mask),
        .hit_valid   (hit_valid),
        .hit         (hit),
        .hit_idx     (hit_idx)
    );

    action_table action_table_inst (
        .clk       (clk),
        .wr_en     (act_wr_en),
        .wr_idx    (act_wr_idx),
        .wr_data   (act_wr_data),
        .rd_idx    (hit_idx),
        .rd_action (rd_action)
    );

    lookup_result lookup_result_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_valid    (key_valid),
        .phv_in       (phv_in),
        .hit_valid    (hit_valid),
        .hit          (hit),
        .rd_action    (rd_action),
        .action       (action),
        .action_valid (action_valid),
        .phv_out      (phv_out)
    );

endmodule

// ==== test/tb_lookup_engine.sv ====
// Testbench for the match-action lookup stage.
// Keeps reference CAM and action tables, predicts every lookup result and
// forwarded control beat, and checks them against the DUT at the falling edge.
module tb_lookup_engine;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [47:0] DEFAULT_ACTION = 48'h3f;
    localparam logic [4:0]  STAGE_ID       = 5'd1;
    localparam logic [2:0]  LOOKUP_ID      = 3'd2;
    localparam logic [3:0]  RESV_CAM       = 4'd0;
    localparam logic [3:0]  RESV_ACT       = 4'd2;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        key_valid;
    logic [23:0] extract_key;
    logic [23:0] extract_mask;
    logic [63:0] phv_in;
    logic [47:0] action;
    logic        action_valid;
    logic [63:0] phv_out;
    logic [63:0] c_in_data;
    logic        c_in_valid;
    logic        c_in_last;
    logic [63:0] c_out_data;
    logic        c_out_valid;
    logic        c_out_last;

    int          cycle = 0;
    logic [31:0] lfsr;
    string       test_name = "";

    // reference model of both tables
    logic [23:0] ref_key [16];
    logic [23:0] ref_mask [16];
    logic        ref_valid [16];
    logic [47:0] ref_act [16];

    logic [23:0] pend_key [$];
    logic [23:0] pend_mask [$];

    logic [47:0] exp_act_q [$];
    logic [63:0] exp_phv_q [$];
    int          exp_cyc_q [$];
    logic [63:0] fwd_data_q [$];
    logic        fwd_last_q [$];
    int          fwd_cyc_q [$];

    lookup_engine lookup_engine_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_valid    (key_valid),
        .extract_key  (extract_key),
        .extract_mask (extract_mask),
        .phv_in       (phv_in),
        .action       (action),
        .action_valid (action_valid),
        .phv_out      (phv_out),
        .c_in_data    (c_in_data),
        .c_in_valid   (c_in_valid),
        .c_in_last    (c_in_last),
        .c_out_data   (c_out_data),
        .c_out_valid  (c_out_valid),
        .c_out_last   (c_out_last)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic fail_now();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic fail_with(string msg);
        $display("%s", msg);
        fail_now();
    endtask

    task automatic report_mismatch(string what, logic [63:0] exp, logic [63:0] act);
        $display("[ERROR] %s: %s expected %0h, got %0h", test_name, what, exp, act);
        fail_now();
    endtask

    // galois lfsr stepped once per bit handed out
    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[62:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
        end
        return r;
    endfunction

    function automatic logic [23:0] rand_key();
        logic [63:0] r;
        r = rand_bits(24);
        return r[23:0];
    endfunction

    function automatic logic [47:0] rand_act();
        logic [63:0] r;
        r = rand_bits(48);
        return r[47:0];
    endfunction

    function automatic logic [63:0] header(logic [4:0] stage, logic [2:0] lkp,
                                           logic [3:0] resv, logic [7:0] index);
        logic [63:0] r;
        r = rand_bits(44);
        return {stage, lkp, resv, index, r[43:0]};
    endfunction

    function automatic logic [63:0] payload(logic [47:0] data);
        logic [63:0] r;
        r = rand_bits(16);
        return {r[15:0], data};
    endfunction

    // lowest valid entry whose cared-for bits all agree
    function automatic logic [47:0] expect_action(logic [23:0] key, logic [23:0] mask);
        logic hit;
        for (int i = 0; i < 16; i++) begin
            if (ref_valid[i]) begin
                hit = 1'b1;
                for (int b = 0; b < 24; b++) begin
                    if (!ref_mask[i][b] && !mask[b] && ref_key[i][b] != key[b]) begin
                        hit = 1'b0;
                    end
                end
                if (hit) begin
                    return ref_act[i];
                end
            end
        end
        return DEFAULT_ACTION;
    endfunction

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic idle(int n);
        repeat (n) begin
            tick();
            key_valid  = 1'b0;
            c_in_valid = 1'b0;
            c_in_last  = 1'b0;
        end
    endtask

    task automatic send_beat(logic [63:0] data, logic last, logic fwd);
        tick();
        key_valid  = 1'b0;
        c_in_valid = 1'b1;
        c_in_data  = data;
        c_in_last  = last;
        if (fwd) begin
            fwd_data_q.push_back(data);
            fwd_last_q.push_back(last);
            fwd_cyc_q.push_back(cycle + 1);
        end
    endtask

    task automatic lookup(logic [23:0] key, logic [23:0] mask);
        logic [63:0] phv;
        phv = rand_bits(64);
        tick();
        c_in_valid   = 1'b0;
        c_in_last    = 1'b0;
        key_valid    = 1'b1;
        extract_key  = key;
        extract_mask = mask;
        phv_in       = phv;
        exp_act_q.push_back(expect_action(key, mask));
        exp_phv_q.push_back(phv);
        exp_cyc_q.push_back(cycle + 3);
    endtask

    task automatic act_packet(logic [3:0] idx, logic [47:0] data);
        send_beat(header(STAGE_ID, LOOKUP_ID, RESV_ACT, {4'h0, idx}), 1'b0, 1'b0);
        send_beat(payload(data), 1'b1, 1'b0);
        ref_act[idx] = data;
        idle(3);
    endtask

    // entry then mask for every pending pair with the index counting up
    task automatic cam_packet(logic [3:0] idx);
        int         n;
        logic [3:0] at;
        n  = pend_key.size();
        at = idx;
        send_beat(header(STAGE_ID, LOOKUP_ID, RESV_CAM, {4'h0, idx}), 1'b0, 1'b0);
        for (int i = 0; i < n; i++) begin
            send_beat(payload({rand_key(), pend_key[i]}), 1'b0, 1'b0);
            send_beat(payload({rand_key(), pend_mask[i]}), i == n - 1, 1'b0);
            ref_key[at]   = pend_key[i];
            ref_mask[at]  = pend_mask[i];
            ref_valid[at] = 1'b1;
            at = at + 4'd1;
        end
        pend_key.delete();
        pend_mask.delete();
        idle(3);
    endtask

    task automatic foreign_packet(logic [4:0] stage, logic [2:0] lkp, logic [3:0] resv,
                                  int beats);
        send_beat(header(stage, lkp, resv, 8'h00), beats == 1, 1'b1);
        for (int i = 1; i < beats; i++) begin
            send_beat(payload(rand_act()), i == beats - 1, 1'b1);
        end
        idle(1);
    endtask

    task automatic drain(int limit);
        int n;
        n = 0;
        idle(1);
        while (exp_cyc_q.size() != 0 || fwd_cyc_q.size() != 0) begin
            if (n == limit) begin
                fail_with("timed out waiting for outstanding lookups or forwarded beats");
            end else begin
                @(posedge clk);
                n++;
            end
        end
    endtask

    task automatic check_lookup();
        if (action_valid) begin
            if (exp_cyc_q.size() == 0) begin
                fail_with("action_valid went high with no lookup outstanding");
            end else begin
                assert (cycle == exp_cyc_q[0])
                    else report_mismatch("result cycle", 64'(exp_cyc_q[0]), 64'(cycle));
                assert (action == exp_act_q[0])
                    else report_mismatch("action", 64'(exp_act_q[0]), 64'(action));
                assert (phv_out == exp_phv_q[0])
                    else report_mismatch("phv", exp_phv_q[0], phv_out);
                void'(exp_cyc_q.pop_front());
                void'(exp_act_q.pop_front());
                void'(exp_phv_q.pop_front());
            end
        end else if (exp_cyc_q.size() != 0 && cycle >= exp_cyc_q[0]) begin
            fail_with("action_valid stayed low when a lookup result was due");
        end
    endtask

    task automatic check_forward();
        if (c_out_valid) begin
            if (fwd_cyc_q.size() == 0) begin
                fail_with("c_out_valid went high with no forwarded beat expected");
            end else begin
                assert (cycle == fwd_cyc_q[0])
                    else report_mismatch("forward cycle", 64'(fwd_cyc_q[0]), 64'(cycle));
                assert (c_out_data == fwd_data_q[0])
                    else report_mismatch("c_out_data", fwd_data_q[0], c_out_data);
                assert (c_out_last == fwd_last_q[0])
                    else report_mismatch("c_out_last", 64'(fwd_last_q[0]), 64'(c_out_last));
                void'(fwd_cyc_q.pop_front());
                void'(fwd_data_q.pop_front());
                void'(fwd_last_q.pop_front());
            end
        end else if (fwd_cyc_q.size() != 0 && cycle >= fwd_cyc_q[0]) begin
            fail_with("c_out_valid stayed low when a forwarded beat was due");
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            check_lookup();
            check_forward();
        end
    end

    initial begin
        logic [23:0] k;
        logic [23:0] m;
        logic [23:0] lm;
        logic [23:0] d;
        logic [63:0] r;
        lfsr         = 32'h9e996a09;
        rst_n        = 1'b0;
        key_valid    = 1'b0;
        extract_key  = '0;
        extract_mask = '0;
        phv_in       = '0;
        c_in_data    = '0;
        c_in_valid   = 1'b0;
        c_in_last    = 1'b0;
        for (int i = 0; i < 16; i++) begin
            ref_key[i]   = '0;
            ref_mask[i]  = '0;
            ref_valid[i] = 1'b0;
            ref_act[i]   = '0;
        end
        repeat (5) @(posedge clk);
        #2 rst_n = 1'b1;

        test_name = "reset_idle";
        idle(6);

        test_name = "empty_table";
        repeat (4) lookup(rand_key(), 24'h0);
        lookup(rand_key(), rand_key());
        drain(20);

        test_name = "single_entry";
        for (int i = 0; i < 16; i++) begin
            act_packet(4'(i), rand_act());
        end
        k = rand_key();
        m = rand_key() & rand_key() & rand_key();
        pend_key.push_back(k);
        pend_mask.push_back(m);
        cam_packet(4'd5);
        lookup(k, 24'h0);
        lookup(k ^ m, 24'h0);
        lm = rand_key() & rand_key();
        lookup(k ^ lm, lm);
        // flip the lowest bit that neither mask ignores
        d = ~m;
        d = d & (~d + 24'd1);
        lookup(k ^ d, 24'h0);
        drain(20);

        test_name = "priority";
        k = rand_key();
        pend_key.push_back(k);
        pend_mask.push_back(24'h000000);
        pend_key.push_back(k);
        pend_mask.push_back(24'h0000ff);
        pend_key.push_back(k);
        pend_mask.push_back(24'hfff000);
        cam_packet(4'd8);
        lookup(k, 24'h0);
        lookup(k ^ 24'h000001, 24'h0);
        lookup(k ^ 24'h100000, 24'h0);
        lookup(k ^ 24'h000100, 24'h0);
        drain(20);

        test_name = "random_stream";
        for (int i = 0; i < 48; i++) begin
            r = rand_bits(5);
            k = r[4] ? ref_key[r[3:0]] ^ (rand_key() & rand_key() & rand_key()) : rand_key();
            lookup(k, rand_key() & rand_key() & rand_key());
        end
        drain(20);

        test_name = "forward";
        foreign_packet(5'd3, LOOKUP_ID, RESV_CAM, 3);
        foreign_packet(STAGE_ID, LOOKUP_ID, 4'd5, 2);
        foreign_packet(STAGE_ID, 3'd6, RESV_ACT, 1);
        act_packet(4'd8, rand_act());
        foreign_packet(5'd0, LOOKUP_ID, RESV_ACT, 4);
        lookup(ref_key[8], 24'h0);
        drain(20);

        if (exp_cyc_q.size() == 0 && fwd_cyc_q.size() == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            fail_with("results still outstanding at the end of the run");
        end
    end

endmodule

// ==== sources.f ====
+incdir+logic
logic/ctrl_pkg.sv
logic/lookup_pkg.sv
logic/ctrl_decoder.sv
logic/key_cam.sv
logic/action_table.sv
logic/lookup_result.sv
logic/lookup_engine.sv
test/tb_lookup_engine.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module tb_lookup_engine -o tb_sim

run: compile
	@out="$$(./obj_dir/tb_sim)"; echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
